/* vlog.f */
reg_pw_pkg.sv
reg_access_if.sv
reg_decode.sv
reg_store.sv
reg_control.sv
reg_readback.sv
reg_pw_top.sv
tb_reg_pw.sv

/* Makefile */
# Verilator build and run for the sniffer register block

VERILATOR ?= verilator
TOP       ?= tb_reg_pw
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Errors found

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_reg_pw.sv */
// Table driven testbench for the sniffer register block
// Inputs change 2 ns after the rising edge, outputs are sampled 1 ns after
// the edge that follows, so each table entry takes exactly one clock cycle
// Pattern and mask data come from $random with a fixed seed

`timescale 1ns/10ps
`default_nettype none

module tb_reg_pw import reg_pw_pkg::*; ();

   typedef enum int {OP_IDLE, OP_WRITE, OP_READ, OP_PULSE, OP_WR_PULSE, OP_PSDONE,
                     OP_SPEED_IN} op_e;
   typedef enum int {CHK_RDATA, CHK_ARM, CHK_PSEN, CHK_PSINCDEC, CHK_RESTART, CHK_SPEED,
                     CHK_PATTERN, CHK_MASK, CHK_PBYTES, CHK_TRIG_EN, CHK_CAPLEN,
                     CHK_TDELAY, CHK_TWIDTH, CHK_CDELAY, CHK_WAIT1, CHK_WAIT2, CHK_XCVR,
                     CHK_TERM} port_e;

   logic                       cwusb_clk;
   logic                       reset_i;
   logic [5:0]                 reg_address_i;
   logic [BYTECNT_W-1:0]       reg_bytecnt_i;
   logic [7:0]                 write_data_i;
   logic                       reg_read_i;
   logic                       reg_write_i;
   logic                       reg_addrvalid_i;
   logic [7:0]                 read_data_o;
   logic                       capture_enable_pulse_i;
   logic                       arm_o;
   logic [PATTERN_W-1:0]       pattern_o;
   logic [PATTERN_W-1:0]       pattern_mask_o;
   logic [7:0]                 pattern_bytes_o;
   logic                       trigger_enable_o;
   logic [CAPTURE_LEN_W-1:0]   capture_len_o;
   logic [TRIGGER_DELAY_W-1:0] trigger_delay_o;
   logic [TRIGGER_WIDTH_W-1:0] trigger_width_o;
   logic [CAPTURE_DELAY_W-1:0] capture_delay_o;
   logic [1:0]                 usb_auto_speed_i;
   logic [1:0]                 usb_speed_o;
   logic                       usb_auto_restart_o;
   logic [USB_WAIT_W-1:0]      usb_auto_wait1_o;
   logic [USB_WAIT_W-1:0]      usb_auto_wait2_o;
   logic [1:0]                 usb_xcvrsel_auto_o;
   logic                       usb_termsel_auto_o;
   logic                       psdone_i;
   logic                       psen_o;
   logic                       psincdec_o;

   // Stimulus table, one entry per cycle
   op_e                  op_q[$];
   logic [5:0]           addr_q[$];
   logic [BYTECNT_W-1:0] cnt_q[$];
   logic [7:0]           data_q[$];
   port_e                port_q[$];
   logic [63:0]          exp_q[$];
   string                name_q[$];

   integer seed;
   int     error_cnt;
   int     check_cnt;
   int     cycle_cnt;
   int     max_cycles;

   reg_pw_top DUT (.*);

   initial begin
      cwusb_clk = 1'b0;
      forever #10 cwusb_clk = ~cwusb_clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Table construction
   ////////////////////////////////////////////////////////////////////////////
   task automatic add_step(input string name, input op_e op, input reg_addr_e addr,
                           input int cnt, input logic [7:0] data, input port_e port,
                           input logic [63:0] exp);
      name_q.push_back(name);
      op_q.push_back(op);
      addr_q.push_back(addr);
      cnt_q.push_back(BYTECNT_W'(cnt));
      data_q.push_back(data);
      port_q.push_back(port);
      exp_q.push_back(exp);
   endtask

   // Random lanes written, read back one by one, then seen on the output
   task automatic add_pattern_steps(input reg_addr_e addr, input port_e port,
                                    input string tag);
      logic [63:0] full;
      logic [7:0]  b;
      int          n;
      full = '0;
      n = int'(reg_bytes(addr));
      for (int i = 0; i < n; i++) begin
         b = 8'($random(seed));
         full[i*8 +: 8] = b;
         add_step($sformatf("%s_wr%0d", tag, i), OP_WRITE, addr, i, b, CHK_RDATA, 64'd0);
      end
      for (int i = 0; i < n; i++) begin
         add_step($sformatf("%s_rd%0d", tag, i), OP_READ, addr, i, 8'h00, CHK_RDATA,
                  64'(full[i*8 +: 8]));
      end
      add_step({tag, "_out"}, OP_IDLE, addr, 0, 8'h00, port, full);
   endtask

   task automatic build_table();
      // Reset defaults
      add_step("rst_arm", OP_IDLE, REG_ARM, 0, 8'h00, CHK_ARM, 64'd0);
      add_step("rst_psen", OP_IDLE, REG_ARM, 0, 8'h00, CHK_PSEN, 64'd0);
      add_step("rst_restart", OP_IDLE, REG_ARM, 0, 8'h00, CHK_RESTART, 64'd0);
      add_step("rst_wait1", OP_IDLE, REG_ARM, 0, 8'h00, CHK_WAIT1, 64'd60000);
      add_step("rst_wait2", OP_IDLE, REG_ARM, 0, 8'h00, CHK_WAIT2, 64'd3600000);
      add_step("rst_xcvrsel", OP_IDLE, REG_ARM, 0, 8'h00, CHK_XCVR, 64'd1);
      add_step("rst_termsel", OP_IDLE, REG_ARM, 0, 8'h00, CHK_TERM, 64'd1);
      add_step("rst_rdata", OP_IDLE, REG_ARM, 0, 8'h00, CHK_RDATA, 64'd0);
      add_step("auto_fs", OP_SPEED_IN, REG_ARM, 0, 8'h02, CHK_SPEED, 64'd2);
      add_step("auto_ls", OP_SPEED_IN, REG_ARM, 0, 8'h01, CHK_SPEED, 64'd1);

      // Multi-byte settings
      add_pattern_steps(REG_PATTERN, CHK_PATTERN, "pat");
      add_pattern_steps(REG_PATTERN_MASK, CHK_MASK, "mask");
      add_step("tdly_wr0", OP_WRITE, REG_TRIGGER_DELAY, 0, 8'h12, CHK_RDATA, 64'd0);
      add_step("tdly_wr1", OP_WRITE, REG_TRIGGER_DELAY, 1, 8'h34, CHK_RDATA, 64'd0);
      add_step("tdly_wr2", OP_WRITE, REG_TRIGGER_DELAY, 2, 8'hab, CHK_RDATA, 64'd0);
      add_step("tdly_wr3", OP_WRITE, REG_TRIGGER_DELAY, 3, 8'hff, CHK_RDATA, 64'd0);
      // Top lane keeps 4 bits of 8'hab
      add_step("tdly_out", OP_IDLE, REG_TRIGGER_DELAY, 0, 8'h00, CHK_TDELAY,
               64'h0b3412 & ((64'd1 << TRIGGER_DELAY_W) - 64'd1));
      add_step("pat_rd8", OP_READ, REG_PATTERN, 8, 8'h00, CHK_RDATA, 64'd0);

      // Remaining settings
      add_step("pbytes_wr", OP_WRITE, REG_PATTERN_BYTES, 0, 8'h05, CHK_PBYTES, 64'd5);
      add_step("pbytes_rd", OP_READ, REG_PATTERN_BYTES, 0, 8'h00, CHK_RDATA, 64'd5);
      // Only bit 0 is kept
      add_step("trig_en_wr", OP_WRITE, REG_TRIGGER_ENABLE, 0, 8'hff, CHK_TRIG_EN, 64'd1);
      add_step("trig_en_rd", OP_READ, REG_TRIGGER_ENABLE, 0, 8'h00, CHK_RDATA, 64'd1);
      add_step("caplen_wr0", OP_WRITE, REG_CAPTURE_LEN, 0, 8'h78, CHK_RDATA, 64'd0);
      add_step("caplen_wr1", OP_WRITE, REG_CAPTURE_LEN, 1, 8'h56, CHK_CAPLEN, 64'h5678);
      add_step("caplen_rd", OP_READ, REG_CAPTURE_LEN, 0, 8'h00, CHK_RDATA, 64'd0);
      add_step("twidth_wr1", OP_WRITE, REG_TRIGGER_WIDTH, 1, 8'h9a, CHK_TWIDTH, 64'h9a00);
      // 18 bit delay, top lane keeps 2 bits
      add_step("cdly_wr2", OP_WRITE, REG_CAPTURE_DELAY, 2, 8'hff, CHK_CDELAY, 64'h30000);

      // ARM
      add_step("arm_set", OP_WRITE, REG_ARM, 0, 8'h01, CHK_ARM, 64'd1);
      add_step("arm_rd", OP_READ, REG_ARM, 0, 8'h00, CHK_RDATA, 64'd1);
      add_step("arm_pulse", OP_PULSE, REG_ARM, 0, 8'h00, CHK_ARM, 64'd0);
      add_step("arm_wr_pulse", OP_WR_PULSE, REG_ARM, 0, 8'h01, CHK_ARM, 64'd1);
      add_step("arm_rd2", OP_READ, REG_ARM, 0, 8'h00, CHK_RDATA, 64'd1);

      // USB speed
      add_step("hs_restart", OP_WRITE, REG_USB_SPEED, 0, 8'h03, CHK_RESTART, 64'd0);
      add_step("hs_speed", OP_IDLE, REG_USB_SPEED, 0, 8'h00, CHK_SPEED, 64'd3);
      add_step("hs_rd", OP_READ, REG_USB_SPEED, 0, 8'h00, CHK_RDATA, 64'd3);
      add_step("auto_restart", OP_WRITE, REG_USB_SPEED, 0, 8'h00, CHK_RESTART, 64'd1);
      add_step("auto_restart_end", OP_IDLE, REG_USB_SPEED, 0, 8'h00, CHK_RESTART, 64'd0);
      add_step("auto_speed", OP_IDLE, REG_USB_SPEED, 0, 8'h00, CHK_SPEED, 64'd1);
      add_step("auto_rd", OP_READ, REG_USB_SPEED, 0, 8'h00, CHK_RDATA, 64'd1);

      // Phase shift
      add_step("ps_psen", OP_WRITE, REG_TRIG_CLK_PHASE_SHIFT, 0, 8'h01, CHK_PSEN, 64'd1);
      add_step("ps_psen_end", OP_IDLE, REG_ARM, 0, 8'h00, CHK_PSEN, 64'd0);
      add_step("ps_incdec", OP_IDLE, REG_ARM, 0, 8'h00, CHK_PSINCDEC, 64'd1);
      add_step("ps_rd", OP_READ, REG_TRIG_CLK_PHASE_SHIFT, 0, 8'h00, CHK_RDATA, 64'd1);
      add_step("ps_busy_wr", OP_WRITE, REG_TRIG_CLK_PHASE_SHIFT, 0, 8'h00, CHK_PSEN, 64'd0);
      add_step("ps_busy_incdec", OP_IDLE, REG_ARM, 0, 8'h00, CHK_PSINCDEC, 64'd1);
      add_step("ps_done", OP_PSDONE, REG_ARM, 0, 8'h00, CHK_PSEN, 64'd0);
      add_step("ps_rd_idle", OP_READ, REG_TRIG_CLK_PHASE_SHIFT, 0, 8'h00, CHK_RDATA, 64'd0);
      add_step("ps_psen2", OP_WRITE, REG_TRIG_CLK_PHASE_SHIFT, 0, 8'h00, CHK_PSEN, 64'd1);
      add_step("ps_incdec2", OP_IDLE, REG_ARM, 0, 8'h00, CHK_PSINCDEC, 64'd0);
      add_step("ps_psen2_end", OP_IDLE, REG_ARM, 0, 8'h00, CHK_PSEN, 64'd0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Drive and check
   ////////////////////////////////////////////////////////////////////////////
   task automatic drive_step(input int i);
      reg_address_i          = addr_q[i];
      reg_bytecnt_i          = cnt_q[i];
      write_data_i           = data_q[i];
      reg_addrvalid_i        = 1'b0;
      reg_write_i            = 1'b0;
      reg_read_i             = 1'b0;
      capture_enable_pulse_i = 1'b0;
      psdone_i               = 1'b0;
      case (op_q[i])
         OP_WRITE, OP_WR_PULSE: begin
            reg_addrvalid_i = 1'b1;
            reg_write_i     = 1'b1;
            capture_enable_pulse_i = (op_q[i] == OP_WR_PULSE);
         end
         OP_READ: begin
            reg_addrvalid_i = 1'b1;
            reg_read_i      = 1'b1;
         end
         OP_PULSE:    capture_enable_pulse_i = 1'b1;
         OP_PSDONE:   psdone_i = 1'b1;
         OP_SPEED_IN: usb_auto_speed_i = data_q[i][1:0];
         default: ;
      endcase
   endtask

   function automatic logic [63:0] port_value(input port_e port);
      case (port)
         CHK_RDATA:    return 64'(read_data_o);
         CHK_ARM:      return 64'(arm_o);
         CHK_PSEN:     return 64'(psen_o);
         CHK_PSINCDEC: return 64'(psincdec_o);
         CHK_RESTART:  return 64'(usb_auto_restart_o);
         CHK_SPEED:    return 64'(usb_speed_o);
         CHK_PATTERN:  return 64'(pattern_o);
         CHK_MASK:     return 64'(pattern_mask_o);
         CHK_PBYTES:   return 64'(pattern_bytes_o);
         CHK_TRIG_EN:  return 64'(trigger_enable_o);
         CHK_CAPLEN:   return 64'(capture_len_o);
         CHK_TDELAY:   return 64'(trigger_delay_o);
         CHK_TWIDTH:   return 64'(trigger_width_o);
         CHK_CDELAY:   return 64'(capture_delay_o);
         CHK_WAIT1:    return 64'(usb_auto_wait1_o);
         CHK_WAIT2:    return 64'(usb_auto_wait2_o);
         CHK_XCVR:     return 64'(usb_xcvrsel_auto_o);
         default:      return 64'(usb_termsel_auto_o);
      endcase
   endfunction

   task automatic check_val(input string name, input logic [63:0] exp,
                            input logic [63:0] act);
      check_cnt++;
      if (act !== exp) begin
         error_cnt++;
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // Watchdog, the limit is set once the table exists
   initial begin
      cycle_cnt = 0;
      #1;
      while (cycle_cnt < max_cycles) begin
         @(posedge cwusb_clk);
         cycle_cnt++;
      end
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Errors found");
      $finish;
   end

   initial begin
      reset_i                = 1'b1;
      reg_address_i          = 6'd0;
      reg_bytecnt_i          = '0;
      write_data_i           = 8'h00;
      reg_read_i             = 1'b0;
      reg_write_i            = 1'b0;
      reg_addrvalid_i        = 1'b0;
      capture_enable_pulse_i = 1'b0;
      usb_auto_speed_i       = 2'd0;
      psdone_i               = 1'b0;
      seed                   = 32'h8824;
      error_cnt              = 0;
      check_cnt              = 0;
      build_table();
      max_cycles = 4 * op_q.size() + 50;

      repeat (3) @(posedge cwusb_clk);
      #2;
      reset_i = 1'b0;
      for (int i = 0; i < op_q.size(); i++) begin
         drive_step(i);
         @(posedge cwusb_clk);
         #1;
         check_val(name_q[i], exp_q[i], port_value(port_q[i]));
         #1;
      end

      $display("Run complete: %0d checks, %0d errors", check_cnt, error_cnt);
      if (error_cnt == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

/* reg_pw_top.sv */
// Configuration register block of the USB sniffer, single clock domain
// All inputs, including the capture pulse, must be synchronous to cwusb_clk
// Read data appears one cycle after reg_read and is zero otherwise

`timescale 1ns/10ps
`default_nettype none

module reg_pw_top import reg_pw_pkg::*; (
   input  wire                        cwusb_clk,
   input  wire                        reset_i,
   // Host register bus
   input  wire  [5:0]                 reg_address_i,
   input  wire  [BYTECNT_W-1:0]       reg_bytecnt_i,
   input  wire  [7:0]                 write_data_i,
   input  wire                        reg_read_i,
   input  wire                        reg_write_i,
   input  wire                        reg_addrvalid_i,
   output logic [7:0]                 read_data_o,
   // Capture and pattern matcher
   input  wire                        capture_enable_pulse_i,
   output logic                       arm_o,
   output logic [PATTERN_W-1:0]       pattern_o,
   output logic [PATTERN_W-1:0]       pattern_mask_o,
   output logic [7:0]                 pattern_bytes_o,
   output logic                       trigger_enable_o,
   output logic [CAPTURE_LEN_W-1:0]   capture_len_o,
   // Trigger generator
   output logic [TRIGGER_DELAY_W-1:0] trigger_delay_o,
   output logic [TRIGGER_WIDTH_W-1:0] trigger_width_o,
   output logic [CAPTURE_DELAY_W-1:0] capture_delay_o,
   // USB speed autodetect
   input  wire  [1:0]                 usb_auto_speed_i,
   output logic [1:0]                 usb_speed_o,
   output logic                       usb_auto_restart_o,
   output logic [USB_WAIT_W-1:0]      usb_auto_wait1_o,
   output logic [USB_WAIT_W-1:0]      usb_auto_wait2_o,
   output logic [1:0]                 usb_xcvrsel_auto_o,
   output logic                       usb_termsel_auto_o,
   // Trigger clock phase shift
   input  wire                        psdone_i,
   output logic                       psen_o,
   output logic                       psincdec_o
);

   logic       [2:0] usb_auto_defaults;
   usb_speed_e       usb_speed;
   logic             phaseshift_active;

   reg_access_if acc ();

   reg_decode u_decode (
      .reg_address_i   (reg_address_i),
      .reg_bytecnt_i   (reg_bytecnt_i),
      .write_data_i    (write_data_i),
      .reg_read_i      (reg_read_i),
      .reg_write_i     (reg_write_i),
      .reg_addrvalid_i (reg_addrvalid_i),
      .acc             (acc.decoder)
   );

   reg_store u_store (
      .cwusb_clk           (cwusb_clk),
      .reset_i             (reset_i),
      .acc                 (acc.sink),
      .pattern_o           (pattern_o),
      .pattern_mask_o      (pattern_mask_o),
      .pattern_bytes_o     (pattern_bytes_o),
      .trigger_enable_o    (trigger_enable_o),
      .capture_len_o       (capture_len_o),
      .trigger_delay_o     (trigger_delay_o),
      .trigger_width_o     (trigger_width_o),
      .capture_delay_o     (capture_delay_o),
      .usb_auto_defaults_o (usb_auto_defaults),
      .usb_auto_wait1_o    (usb_auto_wait1_o),
      .usb_auto_wait2_o    (usb_auto_wait2_o)
   );

   reg_control u_control (
      .cwusb_clk              (cwusb_clk),
      .reset_i                (reset_i),
      .acc                    (acc.sink),
      .capture_enable_pulse_i (capture_enable_pulse_i),
      .usb_auto_speed_i       (usb_speed_e'(usb_auto_speed_i)),
      .psdone_i               (psdone_i),
      .arm_o                  (arm_o),
      .usb_auto_restart_o     (usb_auto_restart_o),
      .usb_speed_o            (usb_speed),
      .psen_o                 (psen_o),
      .psincdec_o             (psincdec_o),
      .phaseshift_active_o    (phaseshift_active)
   );

   reg_readback u_readback (
      .cwusb_clk           (cwusb_clk),
      .reset_i             (reset_i),
      .acc                 (acc.sink),
      .pattern_i           (pattern_o),
      .pattern_mask_i      (pattern_mask_o),
      .pattern_bytes_i     (pattern_bytes_o),
      .trigger_enable_i    (trigger_enable_o),
      .arm_i               (arm_o),
      .usb_speed_i         (usb_speed),
      .phaseshift_active_i (phaseshift_active),
      .read_data_o         (read_data_o)
   );

   assign usb_speed_o        = usb_speed;
   assign usb_xcvrsel_auto_o = usb_auto_defaults[1:0];
   assign usb_termsel_auto_o = usb_auto_defaults[2];

endmodule

`default_nettype wire

/* reg_readback.sv */
// Registered read data, valid the cycle after the read strobe
// Write only settings and unmapped lanes read as zero
// Output is zero in every cycle without a read

`timescale 1ns/10ps
`default_nettype none

module reg_readback import reg_pw_pkg::*; (
   input  wire                  cwusb_clk,
   input  wire                  reset_i,
   reg_access_if.sink           acc,
   input  wire [PATTERN_W-1:0]  pattern_i,
   input  wire [PATTERN_W-1:0]  pattern_mask_i,
   input  wire [7:0]            pattern_bytes_i,
   input  wire                  trigger_enable_i,
   input  wire                  arm_i,
   input  wire usb_speed_e      usb_speed_i,
   input  wire                  phaseshift_active_i,
   output logic [7:0]           read_data_o
);

   logic [5:0] lane_lsb;

   assign lane_lsb = {acc.acc_byte, 3'b000};

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         read_data_o <= 8'h00;
      end else if (acc.acc_rd) begin
         case (acc.acc_addr)
            REG_ARM:                  read_data_o <= {7'b0, arm_i};
            REG_PATTERN:              read_data_o <= pattern_i[lane_lsb +: 8];
            REG_PATTERN_MASK:         read_data_o <= pattern_mask_i[lane_lsb +: 8];
            REG_TRIGGER_ENABLE:       read_data_o <= {7'b0, trigger_enable_i};
            REG_PATTERN_BYTES:        read_data_o <= pattern_bytes_i;
            // Effective speed, so AUTO shows the detected value
            REG_USB_SPEED:            read_data_o <= {6'b0, usb_speed_i};
            REG_TRIG_CLK_PHASE_SHIFT: read_data_o <= {7'b0, phaseshift_active_i};
            default:                  read_data_o <= 8'h00;
         endcase
      end else begin
         read_data_o <= 8'h00;
      end
   end

endmodule

`default_nettype wire

/* reg_control.sv */
// Registers with side effects: ARM, USB speed and trigger clock phase shift
// capture_enable_pulse_i must already be synchronous to cwusb_clk
// Phase shift follows the usual MMCM handshake, psen for one cycle then
// wait for psdone, and writes during that wait are dropped

`timescale 1ns/10ps
`default_nettype none

module reg_control import reg_pw_pkg::*; (
   input  wire              cwusb_clk,
   input  wire              reset_i,
   reg_access_if.sink       acc,
   input  wire              capture_enable_pulse_i,
   input  wire usb_speed_e  usb_auto_speed_i,
   input  wire              psdone_i,
   output logic             arm_o,
   output logic             usb_auto_restart_o,
   output usb_speed_e       usb_speed_o,
   output logic             psen_o,
   output logic             psincdec_o,
   output logic             phaseshift_active_o
);

   logic       wr_arm;
   logic       wr_speed;
   logic       wr_ps;
   usb_speed_e speed_sel_q;
   usb_speed_e auto_speed_q;
   ps_state_e  ps_state;

   assign wr_arm   = acc.acc_wr && (acc.acc_addr == REG_ARM);
   assign wr_speed = acc.acc_wr && (acc.acc_addr == REG_USB_SPEED);
   assign wr_ps    = acc.acc_wr && (acc.acc_addr == REG_TRIG_CLK_PHASE_SHIFT);

   ////////////////////////////////////////////////////////////////////////////
   // ARM and USB speed
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         arm_o              <= 1'b0;
         speed_sel_q        <= USB_SPEED_AUTO;
         auto_speed_q       <= USB_SPEED_AUTO;
         usb_auto_restart_o <= 1'b0;
      end else begin
         // Host write beats a capture pulse in the same cycle
         if (wr_arm)
            arm_o <= acc.acc_data[0];
         else if (capture_enable_pulse_i)
            arm_o <= 1'b0;

         auto_speed_q <= usb_auto_speed_i;
         if (wr_speed)
            speed_sel_q <= usb_speed_e'(acc.acc_data[1:0]);
         // Selecting AUTO restarts the speed detector
         usb_auto_restart_o <= wr_speed &&
                               (usb_speed_e'(acc.acc_data[1:0]) == USB_SPEED_AUTO);
      end
   end

   assign usb_speed_o = (speed_sel_q == USB_SPEED_AUTO) ? auto_speed_q : speed_sel_q;

   ////////////////////////////////////////////////////////////////////////////
   // Phase shift FSM
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         ps_state   <= PS_IDLE;
         psen_o     <= 1'b0;
         psincdec_o <= 1'b0;
      end else begin
         psen_o <= 1'b0;
         case (ps_state)
            PS_IDLE: begin
               if (wr_ps) begin
                  psen_o     <= 1'b1;
                  psincdec_o <= acc.acc_data[0];
                  ps_state   <= PS_ACTIVE;
               end
            end
            PS_ACTIVE: begin
               if (psdone_i)
                  ps_state <= PS_IDLE;
            end
            default: ps_state <= PS_IDLE;
         endcase
      end
   end

   assign phaseshift_active_o = (ps_state == PS_ACTIVE);

   // psen is a single cycle request
   assert property (@(posedge cwusb_clk) disable iff (reset_i)
      psen_o |=> !psen_o);

   // A new request only starts from idle
   assert property (@(posedge cwusb_clk) disable iff (reset_i)
      $rose(psen_o) |-> ($past(ps_state) == PS_IDLE));

endmodule

`default_nettype wire

/* reg_store.sv */
// Plain configuration registers, written one byte lane at a time
// Lanes beyond a register's width are dropped, so the top byte of a
// 20 bit delay keeps only its low 4 bits
// These registers are write only from the host side except the
// pattern group, which the readback block also sees

`timescale 1ns/10ps
`default_nettype none

module reg_store import reg_pw_pkg::*; (
   input  wire                        cwusb_clk,
   input  wire                        reset_i,
   reg_access_if.sink                 acc,
   output logic [PATTERN_W-1:0]       pattern_o,
   output logic [PATTERN_W-1:0]       pattern_mask_o,
   output logic [7:0]                 pattern_bytes_o,
   output logic                       trigger_enable_o,
   output logic [CAPTURE_LEN_W-1:0]   capture_len_o,
   output logic [TRIGGER_DELAY_W-1:0] trigger_delay_o,
   output logic [TRIGGER_WIDTH_W-1:0] trigger_width_o,
   output logic [CAPTURE_DELAY_W-1:0] capture_delay_o,
   output logic [2:0]                 usb_auto_defaults_o,
   output logic [USB_WAIT_W-1:0]      usb_auto_wait1_o,
   output logic [USB_WAIT_W-1:0]      usb_auto_wait2_o
);

   // Replace one byte lane of a value held in a 64 bit container
   function automatic logic [63:0] put_byte(input logic [63:0] cur,
                                            input logic [2:0]  idx,
                                            input logic [7:0]  b);
      logic [63:0] res;
      res = cur;
      res[{idx, 3'b000} +: 8] = b;
      return res;
   endfunction

   logic [63:0] lane_src;
   logic [63:0] lane_new;

   // Current value of the addressed setting, zero extended
   always_comb begin
      case (acc.acc_addr)
         REG_PATTERN:        lane_src = pattern_o;
         REG_PATTERN_MASK:   lane_src = pattern_mask_o;
         REG_CAPTURE_LEN:    lane_src = 64'(capture_len_o);
         REG_TRIGGER_DELAY:  lane_src = 64'(trigger_delay_o);
         REG_TRIGGER_WIDTH:  lane_src = 64'(trigger_width_o);
         REG_CAPTURE_DELAY:  lane_src = 64'(capture_delay_o);
         REG_USB_AUTO_WAIT1: lane_src = 64'(usb_auto_wait1_o);
         REG_USB_AUTO_WAIT2: lane_src = 64'(usb_auto_wait2_o);
         default:            lane_src = 64'd0;
      endcase
   end

   assign lane_new = put_byte(lane_src, acc.acc_byte, acc.acc_data);

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         pattern_o           <= '0;
         pattern_mask_o      <= '0;
         pattern_bytes_o     <= '0;
         trigger_enable_o    <= 1'b0;
         capture_len_o       <= '0;
         trigger_delay_o     <= '0;
         trigger_width_o     <= '0;
         capture_delay_o     <= '0;
         usb_auto_defaults_o <= USB_AUTO_DEFAULTS_RESET;
         usb_auto_wait1_o    <= USB_WAIT1_RESET;
         usb_auto_wait2_o    <= USB_WAIT2_RESET;
      end else if (acc.acc_wr) begin
         // Truncation on assignment masks the unused upper bits
         case (acc.acc_addr)
            REG_PATTERN:           pattern_o <= lane_new;
            REG_PATTERN_MASK:      pattern_mask_o <= lane_new;
            REG_TRIGGER_ENABLE:    trigger_enable_o <= acc.acc_data[0];
            REG_PATTERN_BYTES:     pattern_bytes_o <= acc.acc_data;
            REG_CAPTURE_LEN:       capture_len_o <= CAPTURE_LEN_W'(lane_new);
            REG_TRIGGER_DELAY:     trigger_delay_o <= TRIGGER_DELAY_W'(lane_new);
            REG_TRIGGER_WIDTH:     trigger_width_o <= TRIGGER_WIDTH_W'(lane_new);
            REG_CAPTURE_DELAY:     capture_delay_o <= CAPTURE_DELAY_W'(lane_new);
            REG_USB_AUTO_DEFAULTS: usb_auto_defaults_o <= acc.acc_data[2:0];
            REG_USB_AUTO_WAIT1:    usb_auto_wait1_o <= USB_WAIT_W'(lane_new);
            REG_USB_AUTO_WAIT2:    usb_auto_wait2_o <= USB_WAIT_W'(lane_new);
            // ARM, speed and phase shift live in reg_control
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

/* reg_decode.sv */
// Host bus decoder, purely combinational
// Strobes only pass for mapped addresses with the byte count in range,
// so the register blocks downstream never see an out of range lane
// The host is expected never to read and write in the same cycle

`timescale 1ns/10ps
`default_nettype none

module reg_decode import reg_pw_pkg::*; (
   input  wire  [5:0]           reg_address_i,
   input  wire  [BYTECNT_W-1:0] reg_bytecnt_i,
   input  wire  [7:0]           write_data_i,
   input  wire                  reg_read_i,
   input  wire                  reg_write_i,
   input  wire                  reg_addrvalid_i,
   reg_access_if.decoder        acc
);

   reg_addr_e  addr;
   logic [3:0] nbytes;
   logic       in_range;

   assign addr   = reg_addr_e'(reg_address_i);
   assign nbytes = reg_bytes(addr);

   // Unmapped addresses give zero bytes and fail here
   assign in_range = reg_addrvalid_i && (reg_bytecnt_i < BYTECNT_W'(nbytes));

   assign acc.acc_wr   = in_range && reg_write_i;
   assign acc.acc_rd   = in_range && reg_read_i;
   assign acc.acc_addr = addr;
   assign acc.acc_byte = reg_bytecnt_i[2:0];
   assign acc.acc_data = write_data_i;

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////
   // A read and a write together would update and sample the same register
   always_comb begin
      assert (!(acc.acc_wr && acc.acc_rd))
         else $error("Host issued a read and a write in the same cycle");
   end

endmodule

`default_nettype wire

/* reg_access_if.sv */
// One decoded register access, already range checked by the decoder
// Strobes last a single cycle and there is no back-pressure

`timescale 1ns/10ps
`default_nettype none

interface reg_access_if import reg_pw_pkg::*; ();

   logic      acc_wr;
   logic      acc_rd;
   reg_addr_e acc_addr;
   // Byte lane within the addressed register
   logic [2:0] acc_byte;
   logic [7:0] acc_data;

   modport decoder (
      output acc_wr, acc_rd, acc_addr, acc_byte, acc_data
   );

   modport sink (
      input acc_wr, acc_rd, acc_addr, acc_byte, acc_data
   );

endinterface

`default_nettype wire

/* reg_pw_pkg.sv */
// Shared widths, register map and types for the sniffer register block
// Register numbering is local to this block and not host compatible
// Multi-byte settings are little endian, byte 0 holds bits 7:0
// Unmapped addresses have a byte width of zero and are never accessed

`default_nettype none

package reg_pw_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////////////////////
   localparam int PATTERN_BYTES   = 8;
   localparam int PATTERN_W       = 8 * PATTERN_BYTES;
   localparam int BYTECNT_W       = 7;
   localparam int CAPTURE_LEN_W   = 16;
   localparam int TRIGGER_DELAY_W = 20;
   localparam int TRIGGER_WIDTH_W = 16;
   localparam int CAPTURE_DELAY_W = 18;
   localparam int USB_WAIT_W      = 24;

   // About 1 ms and 60 ms of USB clock
   localparam logic [USB_WAIT_W-1:0] USB_WAIT1_RESET = 24'd60000;
   localparam logic [USB_WAIT_W-1:0] USB_WAIT2_RESET = 24'd3600000;

   // termsel in bit 2, xcvrsel in bits 1:0, full speed defaults
   localparam logic [2:0] USB_AUTO_DEFAULTS_RESET = 3'b101;

   ////////////////////////////////////////////////////////////////////////////
   // Types
   ////////////////////////////////////////////////////////////////////////////
   typedef enum logic [5:0] {
      REG_ARM                  = 6'd0,
      REG_PATTERN              = 6'd1,
      REG_PATTERN_MASK         = 6'd2,
      REG_TRIGGER_ENABLE       = 6'd3,
      REG_PATTERN_BYTES        = 6'd4,
      REG_CAPTURE_LEN          = 6'd5,
      REG_TRIGGER_DELAY        = 6'd6,
      REG_TRIGGER_WIDTH        = 6'd7,
      REG_CAPTURE_DELAY        = 6'd8,
      REG_USB_SPEED            = 6'd9,
      REG_USB_AUTO_DEFAULTS    = 6'd10,
      REG_USB_AUTO_WAIT1       = 6'd11,
      REG_USB_AUTO_WAIT2       = 6'd12,
      REG_TRIG_CLK_PHASE_SHIFT = 6'd13
   } reg_addr_e;

   typedef enum logic [1:0] {
      USB_SPEED_AUTO = 2'd0,
      USB_SPEED_LS   = 2'd1,
      USB_SPEED_FS   = 2'd2,
      USB_SPEED_HS   = 2'd3
   } usb_speed_e;

   typedef enum logic {
      PS_IDLE   = 1'b0,
      PS_ACTIVE = 1'b1
   } ps_state_e;

   // Number of host bytes behind each address, zero when unmapped
   function automatic logic [3:0] reg_bytes(input reg_addr_e addr);
      case (addr)
         REG_PATTERN, REG_PATTERN_MASK: return 4'(PATTERN_BYTES);
         REG_CAPTURE_LEN:               return 4'((CAPTURE_LEN_W + 7) / 8);
         REG_TRIGGER_DELAY:             return 4'((TRIGGER_DELAY_W + 7) / 8);
         REG_TRIGGER_WIDTH:             return 4'((TRIGGER_WIDTH_W + 7) / 8);
         REG_CAPTURE_DELAY:             return 4'((CAPTURE_DELAY_W + 7) / 8);
         REG_USB_AUTO_WAIT1,
         REG_USB_AUTO_WAIT2:            return 4'((USB_WAIT_W + 7) / 8);
         REG_ARM, REG_TRIGGER_ENABLE, REG_PATTERN_BYTES, REG_USB_SPEED,
         REG_USB_AUTO_DEFAULTS,
         REG_TRIG_CLK_PHASE_SHIFT:      return 4'd1;
         default:                       return 4'd0;
      endcase
   endfunction

endpackage

`default_nettype wire
